/* all.f */
+incdir+include
design/req_block_pkg.sv
design/rr_arb_tree.sv
design/ch_mux2.sv
design/req_block_top.sv
bench/tb_clkgen.sv
bench/req_block_chk.sv
bench/tb_req_block.sv

/* Bender.yml */
package:
  name: req_block

sources:
  - include_dirs:
      - include
    files:
      - design/req_block_pkg.sv
      - design/rr_arb_tree.sv
      - design/ch_mux2.sv
      - design/req_block_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_clkgen.sv
      - bench/req_block_chk.sv
      - bench/tb_req_block.sv

/* bench/tb_req_block.sv */
/*
 * Directed tests for req_block_top, each test starts from a fresh reset.
 * Inputs change on the falling edge, outputs are checked a quarter period later.
 */

`include "req_block_defines.svh"

module tb_req_block
    import req_block_pkg::*;
;

    localparam int unsigned N_CH0           = `REQ_N_CH0;
    localparam int unsigned N_CH1           = `REQ_N_CH1;
    localparam int unsigned N_MASTER        = `REQ_N_MASTER;
    localparam int unsigned CLK_PERIOD      = 100;
    localparam int unsigned SETTLE          = CLK_PERIOD / 4;
    localparam int unsigned N_TESTS         = 6;
    localparam int unsigned CYCLES_PER_TEST = 40;
    localparam int unsigned TIMEOUT         = N_TESTS * CYCLES_PER_TEST * CLK_PERIOD;

    logic                 clk;
    logic                 rst_n_i;
    logic [N_CH0-1:0]     data_req_ch0_i;
    addr_t [N_CH0-1:0]    data_addr_ch0_i;
    logic [N_CH0-1:0]     data_wen_ch0_i;
    data_t [N_CH0-1:0]    data_wdata_ch0_i;
    be_t [N_CH0-1:0]      data_be_ch0_i;
    id_t [N_CH0-1:0]      data_id_ch0_i;
    logic [N_CH0-1:0]     data_gnt_ch0_o;
    logic [N_CH1-1:0]     data_req_ch1_i;
    addr_t [N_CH1-1:0]    data_addr_ch1_i;
    logic [N_CH1-1:0]     data_wen_ch1_i;
    data_t [N_CH1-1:0]    data_wdata_ch1_i;
    be_t [N_CH1-1:0]      data_be_ch1_i;
    id_t [N_CH1-1:0]      data_id_ch1_i;
    logic [N_CH1-1:0]     data_gnt_ch1_o;
    logic                 data_req_o;
    addr_t                data_addr_o;
    logic                 data_wen_o;
    data_t                data_wdata_o;
    be_t                  data_be_o;
    id_t                  data_id_o;
    logic                 data_gnt_i;
    logic                 data_r_valid_i;
    id_t                  data_r_id_i;
    logic [N_CH0-1:0]     data_r_valid_ch0_o;
    logic [N_CH1-1:0]     data_r_valid_ch1_o;

    integer      seed = 55;
    int unsigned errors = 0;
    int unsigned checks = 0;
    int unsigned tests_run = 0;

    tb_clkgen #(.PERIOD(CLK_PERIOD)) u_clkgen (.clk_o(clk));

    req_block_top u_dut (.*);

    function automatic logic [N_MASTER-1:0] one_hot(input int k);
        logic [N_MASTER-1:0] v;
        v    = '0;
        v[k] = 1'b1;
        return v;
    endfunction

    function automatic logic [N_MASTER-1:0] grant_vec();
        return {data_gnt_ch1_o, data_gnt_ch0_o};
    endfunction

    // Lowest set bit, -1 when none
    function automatic int lowest_bit(input logic [N_MASTER-1:0] v);
        int idx;
        idx = -1;
        for (int i = N_MASTER - 1; i >= 0; i--)
        begin
            if (v[i])
            begin
                idx = i;
            end
        end
        return idx;
    endfunction

    task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string what);
        checks++;
        assert (got === exp)
        else
        begin
            $display("ERROR t=%0t: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic clear_inputs();
        data_req_ch0_i   = '0;
        data_addr_ch0_i  = '0;
        data_wen_ch0_i   = '0;
        data_wdata_ch0_i = '0;
        data_be_ch0_i    = '0;
        data_id_ch0_i    = '0;
        data_req_ch1_i   = '0;
        data_addr_ch1_i  = '0;
        data_wen_ch1_i   = '0;
        data_wdata_ch1_i = '0;
        data_be_ch1_i    = '0;
        data_id_ch1_i    = '0;
        data_gnt_i       = 1'b0;
        data_r_valid_i   = 1'b0;
        data_r_id_i      = '0;
    endtask

    // Random fields for every master, IDs one-hot by global index
    task automatic load_fields();
        for (int m = 0; m < N_CH0; m++)
        begin
            data_addr_ch0_i[m]  = $random(seed);
            data_wen_ch0_i[m]   = $random(seed);
            data_wdata_ch0_i[m] = $random(seed);
            data_be_ch0_i[m]    = $random(seed);
            data_id_ch0_i[m]    = one_hot(m);
        end
        for (int m = 0; m < N_CH1; m++)
        begin
            data_addr_ch1_i[m]  = $random(seed);
            data_wen_ch1_i[m]   = $random(seed);
            data_wdata_ch1_i[m] = $random(seed);
            data_be_ch1_i[m]    = $random(seed);
            data_id_ch1_i[m]    = one_hot(N_CH0 + m);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n_i = 1'b0;
        clear_inputs();
        repeat (2) @(negedge clk);
        rst_n_i = 1'b1;
    endtask

    // Returns at the sample point of the granted cycle
    task automatic await_grant(output int idx, input int max_cycles);
        int n;
        idx = -1;
        n   = 0;
        while (idx < 0 && n < max_cycles)
        begin
            #(SETTLE);
            idx = lowest_bit(grant_vec());
            if (idx < 0)
            begin
                @(negedge clk);
                n++;
            end
        end
        if (idx < 0)
        begin
            $display("No master grant seen within %0d cycles at time %0t", max_cycles, $time);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int unsigned err_before);
        tests_run++;
        $display("%s finished with %0d errors", name, errors - err_before);
    endtask

    task automatic forward_fields();
        int unsigned e0;
        e0 = errors;
        apply_reset();
        load_fields();
        data_req_ch1_i[1] = 1'b1;
        data_gnt_i        = 1'b1;
        #(SETTLE);
        compare(data_req_o, 1'b1, "data_req_o");
        compare(data_addr_o, data_addr_ch1_i[1], "data_addr_o");
        compare(data_wen_o, data_wen_ch1_i[1], "data_wen_o");
        compare(data_wdata_o, data_wdata_ch1_i[1], "data_wdata_o");
        compare(data_be_o, data_be_ch1_i[1], "data_be_o");
        compare(data_id_o, one_hot(N_CH0 + 1), "data_id_o");
        compare(grant_vec(), one_hot(N_CH0 + 1), "master grants");
        @(negedge clk);
        clear_inputs();
        finish_test("forwarding", e0);
    endtask

    task automatic rotate_ch0();
        int unsigned e0;
        e0 = errors;
        apply_reset();
        load_fields();
        data_req_ch0_i = '1;
        data_gnt_i     = 1'b1;
        // Pointer starts at 0 and steps past each winner
        for (int c = 0; c <= N_CH0; c++)
        begin
            #(SETTLE);
            compare(grant_vec(), one_hot(c % N_CH0), "round-robin grant");
            compare(data_id_o, one_hot(c % N_CH0), "round-robin id");
            @(negedge clk);
        end
        clear_inputs();
        finish_test("round robin CH0", e0);
    endtask

    task automatic alternate_channels();
        int unsigned e0;
        int          exp_idx;
        e0 = errors;
        apply_reset();
        load_fields();
        data_req_ch0_i[2] = 1'b1;
        data_req_ch1_i[0] = 1'b1;
        data_gnt_i        = 1'b1;
        for (int c = 0; c < 4; c++)
        begin
            exp_idx = (c % 2 == 0) ? 2 : N_CH0;
            #(SETTLE);
            compare(grant_vec(), one_hot(exp_idx), "channel grant");
            @(negedge clk);
        end
        clear_inputs();
        finish_test("channel alternation", e0);
    endtask

    task automatic hold_under_backpressure();
        int unsigned e0;
        int          idx;
        e0 = errors;
        apply_reset();
        load_fields();
        data_req_ch0_i = 4'b1010;
        for (int c = 0; c < 3; c++)
        begin
            #(SETTLE);
            compare(grant_vec(), '0, "grant while stalled");
            compare(data_req_o, 1'b1, "data_req_o while stalled");
            compare(data_addr_o, data_addr_ch0_i[1], "held address");
            compare(data_wdata_o, data_wdata_ch0_i[1], "held write data");
            @(negedge clk);
        end
        data_gnt_i = 1'b1;
        await_grant(idx, 5);
        compare(idx, 1, "first served master");
        @(negedge clk);
        data_req_ch0_i[1] = 1'b0;
        await_grant(idx, 5);
        compare(idx, 3, "second served master");
        @(negedge clk);
        clear_inputs();
        finish_test("back-pressure", e0);
    endtask

    task automatic route_responses();
        int unsigned e0;
        e0 = errors;
        apply_reset();
        for (int k = 0; k < N_MASTER; k++)
        begin
            data_r_valid_i = 1'b1;
            data_r_id_i    = one_hot(k);
            #(SETTLE);
            compare({data_r_valid_ch1_o, data_r_valid_ch0_o}, one_hot(k), "response valid");
            @(negedge clk);
        end
        data_r_valid_i = 1'b0;
        data_r_id_i    = '1;
        #(SETTLE);
        compare({data_r_valid_ch1_o, data_r_valid_ch0_o}, '0, "response valid when idle");
        @(negedge clk);
        clear_inputs();
        finish_test("response routing", e0);
    endtask

    task automatic stay_idle();
        int unsigned e0;
        e0 = errors;
        apply_reset();
        load_fields();
        data_gnt_i = 1'b1;
        repeat (5)
        begin
            #(SETTLE);
            compare(data_req_o, 1'b0, "data_req_o when idle");
            compare(grant_vec(), '0, "grant when idle");
            @(negedge clk);
        end
        clear_inputs();
        finish_test("idle", e0);
    endtask

    initial
    begin
        rst_n_i = 1'b0;
        clear_inputs();
        forward_fields();
        rotate_ch0();
        alternate_channels();
        hold_under_backpressure();
        route_responses();
        stay_idle();
        errors = errors + u_dut.u_chk.fail_count;
        $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog
    initial
    begin
        #(TIMEOUT);
        $display("Timeout: the tests did not finish within %0d time units", TIMEOUT);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* bench/req_block_chk.sv */
/*
 * Grant protocol checks, bound into every req_block_top instance.
 * fail_count is read by the testbench at the end of the run.
 */

`include "req_block_defines.svh"

module req_block_chk
(
    input logic                  clk,
    input logic                  rst_n_i,
    input logic [`REQ_N_CH0-1:0] data_req_ch0_i,
    input logic [`REQ_N_CH1-1:0] data_req_ch1_i,
    input logic [`REQ_N_CH0-1:0] data_gnt_ch0_o,
    input logic [`REQ_N_CH1-1:0] data_gnt_ch1_o,
    input logic                  data_req_o,
    input logic                  data_gnt_i
);

    logic [`REQ_N_MASTER-1:0] req_all;
    logic [`REQ_N_MASTER-1:0] gnt_all;
    int unsigned              fail_count = 0;

    assign req_all = {data_req_ch1_i, data_req_ch0_i};
    assign gnt_all = {data_gnt_ch1_o, data_gnt_ch0_o};

    a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0(gnt_all))
    else
    begin
        fail_count++;
        $error("more than one master grant is high");
    end

    a_gnt_needs_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        (gnt_all & ~req_all) == '0)
    else
    begin
        fail_count++;
        $error("grant given to a master that does not request");
    end

    a_req_out_source: assert property (@(posedge clk) disable iff (!rst_n_i)
        data_req_o |-> (|req_all))
    else
    begin
        fail_count++;
        $error("memory request without any master request");
    end

    // First cycle out of reset
    a_reset_release: assert property (@(posedge clk)
        $rose(rst_n_i) |-> (gnt_all == '0) || (data_gnt_i && (|req_all)))
    else
    begin
        fail_count++;
        $error("unexpected grant right after reset release");
    end

endmodule

bind req_block_top req_block_chk u_chk (
    .clk            ( clk            ),
    .rst_n_i        ( rst_n_i        ),
    .data_req_ch0_i ( data_req_ch0_i ),
    .data_req_ch1_i ( data_req_ch1_i ),
    .data_gnt_ch0_o ( data_gnt_ch0_o ),
    .data_gnt_ch1_o ( data_gnt_ch1_o ),
    .data_req_o     ( data_req_o     ),
    .data_gnt_i     ( data_gnt_i     )
);

/* bench/tb_clkgen.sv */
/*
 * Free-running testbench clock, starts low at time zero.
 */

module tb_clkgen
#(
    parameter int unsigned PERIOD = 100
)
(
    output logic clk_o
);

    initial
    begin
        clk_o = 1'b0;
    end

    always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

/* design/req_block_top.sv */
/*
 * Request block for one shared memory port, CH0 cores and CH1 DMAs.
 * Masters hold their request until granted; grant and response valid are same-cycle.
 */

`include "req_block_defines.svh"

module req_block_top
    import req_block_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n_i,

    // CH0 masters
    input  logic [`REQ_N_CH0-1:0]       data_req_ch0_i,
    input  addr_t [`REQ_N_CH0-1:0]      data_addr_ch0_i,
    input  logic [`REQ_N_CH0-1:0]       data_wen_ch0_i,
    input  data_t [`REQ_N_CH0-1:0]      data_wdata_ch0_i,
    input  be_t [`REQ_N_CH0-1:0]        data_be_ch0_i,
    input  id_t [`REQ_N_CH0-1:0]        data_id_ch0_i,
    output logic [`REQ_N_CH0-1:0]       data_gnt_ch0_o,

    // CH1 masters
    input  logic [`REQ_N_CH1-1:0]       data_req_ch1_i,
    input  addr_t [`REQ_N_CH1-1:0]      data_addr_ch1_i,
    input  logic [`REQ_N_CH1-1:0]       data_wen_ch1_i,
    input  data_t [`REQ_N_CH1-1:0]      data_wdata_ch1_i,
    input  be_t [`REQ_N_CH1-1:0]        data_be_ch1_i,
    input  id_t [`REQ_N_CH1-1:0]        data_id_ch1_i,
    output logic [`REQ_N_CH1-1:0]       data_gnt_ch1_o,

    // Memory request
    output logic                        data_req_o,
    output addr_t                       data_addr_o,
    output logic                        data_wen_o,
    output data_t                       data_wdata_o,
    output be_t                         data_be_o,
    output id_t                         data_id_o,
    input  logic                        data_gnt_i,

    // Memory response
    input  logic                        data_r_valid_i,
    input  id_t                         data_r_id_i,
    output logic [`REQ_N_CH1-1:0]       data_r_valid_ch1_o,
    output logic [`REQ_N_CH0-1:0]       data_r_valid_ch0_o
);

    localparam int unsigned N_CH0    = `REQ_N_CH0;
    localparam int unsigned N_MASTER = `REQ_N_MASTER;

    // CH0 winner
    logic  req_ch0;
    addr_t addr_ch0;
    logic  wen_ch0;
    data_t wdata_ch0;
    be_t   be_ch0;
    id_t   id_ch0;
    logic  gnt_ch0;

    // CH1 winner
    logic  req_ch1;
    addr_t addr_ch1;
    logic  wen_ch1;
    data_t wdata_ch1;
    be_t   be_ch1;
    id_t   id_ch1;
    logic  gnt_ch1;

    rr_arb_tree #(
        .N_MASTER ( `REQ_N_CH0 )
    ) u_arb_ch0 (
        .clk      ( clk              ),
        .rst_n_i  ( rst_n_i          ),
        .req_i    ( data_req_ch0_i   ),
        .addr_i   ( data_addr_ch0_i  ),
        .wen_i    ( data_wen_ch0_i   ),
        .wdata_i  ( data_wdata_ch0_i ),
        .be_i     ( data_be_ch0_i    ),
        .id_i     ( data_id_ch0_i    ),
        .gnt_o    ( data_gnt_ch0_o   ),
        .req_o    ( req_ch0          ),
        .addr_o   ( addr_ch0         ),
        .wen_o    ( wen_ch0          ),
        .wdata_o  ( wdata_ch0        ),
        .be_o     ( be_ch0           ),
        .id_o     ( id_ch0           ),
        .gnt_i    ( gnt_ch0          )
    );

    rr_arb_tree #(
        .N_MASTER ( `REQ_N_CH1 )
    ) u_arb_ch1 (
        .clk      ( clk              ),
        .rst_n_i  ( rst_n_i          ),
        .req_i    ( data_req_ch1_i   ),
        .addr_i   ( data_addr_ch1_i  ),
        .wen_i    ( data_wen_ch1_i   ),
        .wdata_i  ( data_wdata_ch1_i ),
        .be_i     ( data_be_ch1_i    ),
        .id_i     ( data_id_ch1_i    ),
        .gnt_o    ( data_gnt_ch1_o   ),
        .req_o    ( req_ch1          ),
        .addr_o   ( addr_ch1         ),
        .wen_o    ( wen_ch1          ),
        .wdata_o  ( wdata_ch1        ),
        .be_o     ( be_ch1           ),
        .id_o     ( id_ch1           ),
        .gnt_i    ( gnt_ch1          )
    );

    ch_mux2 u_ch_mux (
        .clk         ( clk          ),
        .rst_n_i     ( rst_n_i      ),
        .req_ch0_i   ( req_ch0      ),
        .addr_ch0_i  ( addr_ch0     ),
        .wen_ch0_i   ( wen_ch0      ),
        .wdata_ch0_i ( wdata_ch0    ),
        .be_ch0_i    ( be_ch0       ),
        .id_ch0_i    ( id_ch0       ),
        .gnt_ch0_o   ( gnt_ch0      ),
        .req_ch1_i   ( req_ch1      ),
        .addr_ch1_i  ( addr_ch1     ),
        .wen_ch1_i   ( wen_ch1      ),
        .wdata_ch1_i ( wdata_ch1    ),
        .be_ch1_i    ( be_ch1       ),
        .id_ch1_i    ( id_ch1       ),
        .gnt_ch1_o   ( gnt_ch1      ),
        .req_o       ( data_req_o   ),
        .addr_o      ( data_addr_o  ),
        .wen_o       ( data_wen_o   ),
        .wdata_o     ( data_wdata_o ),
        .be_o        ( data_be_o    ),
        .id_o        ( data_id_o    ),
        .gnt_i       ( data_gnt_i   )
    );

    // One-hot response ID to per-master valid, low bits are CH0
    assign data_r_valid_ch0_o = {`REQ_N_CH0{data_r_valid_i}} & data_r_id_i[N_CH0-1:0];
    assign data_r_valid_ch1_o = {`REQ_N_CH1{data_r_valid_i}}
                              & data_r_id_i[N_MASTER-1:N_CH0];

endmodule

/* design/ch_mux2.sv */
/*
 * Two-way channel mux with alternating priority, CH0 favored after reset.
 * Selection and grant steering are combinational.
 */

module ch_mux2
    import req_block_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,

    // CH0 winner
    input  logic      req_ch0_i,
    input  addr_t     addr_ch0_i,
    input  logic      wen_ch0_i,
    input  data_t     wdata_ch0_i,
    input  be_t       be_ch0_i,
    input  id_t       id_ch0_i,
    output logic      gnt_ch0_o,

    // CH1 winner
    input  logic      req_ch1_i,
    input  addr_t     addr_ch1_i,
    input  logic      wen_ch1_i,
    input  data_t     wdata_ch1_i,
    input  be_t       be_ch1_i,
    input  id_t       id_ch1_i,
    output logic      gnt_ch1_o,

    // Memory side
    output logic      req_o,
    output addr_t     addr_o,
    output logic      wen_o,
    output data_t     wdata_o,
    output be_t       be_o,
    output id_t       id_o,
    input  logic      gnt_i
);

    ch_prio_e prio_q;
    logic     sel_ch1;

    // CH1 wins when alone or when it holds priority
    assign sel_ch1 = req_ch1_i & (~req_ch0_i | (prio_q == PRIO_CH1));

    assign req_o   = req_ch0_i | req_ch1_i;
    assign addr_o  = sel_ch1 ? addr_ch1_i  : addr_ch0_i;
    assign wen_o   = sel_ch1 ? wen_ch1_i   : wen_ch0_i;
    assign wdata_o = sel_ch1 ? wdata_ch1_i : wdata_ch0_i;
    assign be_o    = sel_ch1 ? be_ch1_i    : be_ch0_i;
    assign id_o    = sel_ch1 ? id_ch1_i    : id_ch0_i;

    assign gnt_ch0_o = gnt_i & req_ch0_i & ~sel_ch1;
    assign gnt_ch1_o = gnt_i & sel_ch1;

    // Favor the channel that was not served
    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            prio_q <= PRIO_CH0;
        end
        else if (req_o && gnt_i)
        begin
            prio_q <= sel_ch1 ? PRIO_CH0 : PRIO_CH1;
        end
    end

endmodule

/* design/rr_arb_tree.sv */
/*
 * Round-robin pick of one master, any N_MASTER of 2 or more.
 * Select and grant are combinational; the pointer moves only on an accepted transfer.
 */

module rr_arb_tree
    import req_block_pkg::*;
#(
    parameter int unsigned N_MASTER = 4
)
(
    input  logic                  clk,
    input  logic                  rst_n_i,

    // Master side
    input  logic [N_MASTER-1:0]   req_i,
    input  addr_t [N_MASTER-1:0]  addr_i,
    input  logic [N_MASTER-1:0]   wen_i,
    input  data_t [N_MASTER-1:0]  wdata_i,
    input  be_t [N_MASTER-1:0]    be_i,
    input  id_t [N_MASTER-1:0]    id_i,
    output logic [N_MASTER-1:0]   gnt_o,

    // Winner towards the channel mux
    output logic                  req_o,
    output addr_t                 addr_o,
    output logic                  wen_o,
    output data_t                 wdata_o,
    output be_t                   be_o,
    output id_t                   id_o,
    input  logic                  gnt_i
);

    localparam int unsigned PTR_W = $clog2(N_MASTER);

    logic [PTR_W-1:0] ptr_q;
    logic [PTR_W-1:0] ptr_nxt;
    logic [PTR_W-1:0] sel_idx;
    logic             found;

    // Index base + off, wrapped at N_MASTER
    function automatic logic [PTR_W-1:0] wrap_idx(input logic [PTR_W-1:0] base,
                                                  input int unsigned      off);
        int unsigned sum;
        sum = int'(base) + off;
        if (sum >= N_MASTER)
        begin
            sum = sum - N_MASTER;
        end
        return PTR_W'(sum);
    endfunction

    // Cyclic search starting at the pointer
    always_comb
    begin
        found   = 1'b0;
        sel_idx = ptr_q;
        for (int unsigned i = 0; i < N_MASTER; i++)
        begin
            if (!found && req_i[wrap_idx(ptr_q, i)])
            begin
                found   = 1'b1;
                sel_idx = wrap_idx(ptr_q, i);
            end
        end
    end

    assign req_o   = found;
    assign addr_o  = addr_i[sel_idx];
    assign wen_o   = wen_i[sel_idx];
    assign wdata_o = wdata_i[sel_idx];
    assign be_o    = be_i[sel_idx];
    assign id_o    = id_i[sel_idx];

    // Grant goes to the selected master only
    always_comb
    begin
        gnt_o          = '0;
        gnt_o[sel_idx] = found & gnt_i;
    end

    // Next pointer sits just past the winner
    assign ptr_nxt = (sel_idx == PTR_W'(N_MASTER - 1)) ? '0 : sel_idx + 1'b1;

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            ptr_q <= '0;
        end
        else if (req_o && gnt_i)
        begin
            ptr_q <= ptr_nxt;
        end
    end

endmodule

/* design/req_block_pkg.sv */
/*
 * Field types shared by the arbiters, the channel mux and the top level.
 * Widths follow the defines header.
 */

`include "req_block_defines.svh"

package req_block_pkg;

    // Request fields
    typedef logic [`REQ_ADDR_W-1:0] addr_t;

    typedef logic [`REQ_DATA_W-1:0] data_t;

    typedef logic [`REQ_BE_W-1:0] be_t;

    // One-hot master ID, bit k belongs to master k
    typedef logic [`REQ_ID_W-1:0] id_t;

    // Channel favored by the mux when both channels request
    typedef enum logic
    {
        PRIO_CH0 = 1'b0,
        PRIO_CH1 = 1'b1
    } ch_prio_e;

endpackage

/* include/req_block_defines.svh */
/*
 * Master counts and field widths. Both channel counts must be 2 or more.
 * IDs are one-hot, CH0 masters take the low bits and CH1 masters the high bits.
 */

`ifndef REQ_BLOCK_DEFINES_SVH
`define REQ_BLOCK_DEFINES_SVH

// Core masters on CH0
`define REQ_N_CH0 4

// DMA masters on CH1
`define REQ_N_CH1 2

`define REQ_N_MASTER (`REQ_N_CH0 + `REQ_N_CH1)

`define REQ_ADDR_W 32

`define REQ_DATA_W 32

// One enable per data byte
`define REQ_BE_W (`REQ_DATA_W / 8)

// One ID bit per master
`define REQ_ID_W `REQ_N_MASTER

`endif
